// File: hw/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl
  import game_pkg::*, io_pkg::*;
(
  input  logic        clk,
  input  logic        out_rst,
  input  logic        start,
  input  key_event_t  key,
  output logic [15:0] leds,
  output game_view_t  view
);

  phase_t             phase;
  phase_t             phase_nxt;
  logic [TICK_W-1:0]  tick_cnt;
  logic               tick;
  logic [FINAL_W-1:0] final_cnt;

  settings_t  settings;
  logic       sel_goal;  // field being typed, 0 is time
  bcd2_t      remain;
  bcd2_t      score;
  logic       win;
  logic [8:0] lfsr;
  logic [8:0] lfsr_nxt;
  logic [8:0] moles;     // lit moles, hits knock them out
  logic       flash;

  logic        digit_key;
  logic [9:0]  key_mask;
  logic        hit;
  logic        goal_met;
  logic        time_out;

  function automatic bcd2_t bcd_inc(bcd2_t v);
    bcd2_t r;
    r = v;
    if (v.lo == 4'd9) begin
      r.lo = 4'd0;
      r.hi = v.hi + 4'd1;
    end else begin
      r.lo = v.lo + 4'd1;
    end
    return r;
  endfunction

  function automatic bcd2_t bcd_dec(bcd2_t v);
    bcd2_t r;
    r = v;
    if (v.lo == 4'd0) begin
      r.lo = 4'd9;
      r.hi = v.hi - 4'd1;
    end else begin
      r.lo = v.lo - 4'd1;
    end
    return r;
  endfunction

  assign tick      = (tick_cnt == TICK_W'(TICK_CYCLES - 1));
  assign goal_met  = (score == settings.goal);
  assign time_out  = (remain == '0);
  assign digit_key = key.valid & key.is_digit;
  assign key_mask  = 10'h001 << key.digit;  // bit k for digit k

  // mole k sits in moles[k-1], digit 0 has no mole
  assign hit = digit_key && |(key_mask[9:1] & moles) && !goal_met;

  // same taps as the original board game
  assign lfsr_nxt = {lfsr[0], lfsr[8], lfsr[7] ^ lfsr[0], lfsr[6] ^ lfsr[0],
                     lfsr[5], lfsr[4] ^ lfsr[0], lfsr[3], lfsr[2], lfsr[1]};

  always_comb begin
    phase_nxt = phase;
    case (phase)
      PH_IDLE:
        if (start) phase_nxt = PH_SET;
      PH_SET:
        if (start) phase_nxt = PH_GAME;
      PH_GAME:
        if (goal_met || time_out) phase_nxt = PH_FINAL;  // goal wins a tie
      PH_FINAL:
        if (tick && final_cnt == FINAL_W'(FINAL_TICKS - 1)) phase_nxt = PH_IDLE;
      default:
        phase_nxt = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk, posedge out_rst) begin
    if (out_rst) begin
      phase     <= PH_IDLE;
      tick_cnt  <= '0;
      final_cnt <= '0;
      settings  <= SETTINGS_DEFAULT;
      sel_goal  <= 1'b0;
      remain    <= '0;
      score     <= '0;
      win       <= 1'b0;
      lfsr      <= LFSR_SEED;
      moles     <= LFSR_SEED;
      flash     <= 1'b1;
    end else begin
      phase <= phase_nxt;
      if (phase_nxt != phase || tick)
        tick_cnt <= '0;  // restart on every phase entry
      else
        tick_cnt <= tick_cnt + 1'b1;

      case (phase)
        PH_IDLE: begin
          settings <= SETTINGS_DEFAULT;
          sel_goal <= 1'b0;
        end
        PH_SET: begin
          if (key.valid && key.is_space)
            sel_goal <= ~sel_goal;
          if (digit_key && !sel_goal)
            settings.time_lim <= '{hi: settings.time_lim.lo, lo: key.digit};
          if (digit_key && sel_goal)
            settings.goal <= '{hi: settings.goal.lo, lo: key.digit};
          if (start) begin
            remain <= settings.time_lim;
            score  <= '0;
            lfsr   <= LFSR_SEED;
            moles  <= LFSR_SEED;
          end
        end
        PH_GAME: begin
          if (hit)
            score <= bcd_inc(score);
          if (tick) begin
            lfsr  <= lfsr_nxt;
            moles <= lfsr_nxt;  // fresh pattern, old hits forgotten
            if (!time_out)
              remain <= bcd_dec(remain);
          end else if (hit) begin
            moles <= moles & ~key_mask[9:1];
          end
          if (phase_nxt == PH_FINAL) begin
            win       <= goal_met;
            flash     <= 1'b1;
            final_cnt <= '0;
          end
        end
        default: begin
          if (tick) begin
            final_cnt <= final_cnt + 1'b1;
            flash     <= ~flash;
          end
        end
      endcase
    end
  end

  always_comb begin
    case (phase)
      PH_IDLE: leds = LED_IDLE;
      PH_SET:  leds = sel_goal ? LED_SET_GOAL : LED_SET_TIME;
      PH_GAME: leds = {moles, LED_GAME_TAIL};
      default: leds = {16{flash}};
    endcase
  end

  always_comb begin
    view.phase    = phase;
    view.time_bcd = (phase == PH_SET) ? settings.time_lim : remain;
    view.goal_bcd = (phase == PH_SET) ? settings.goal : score;
    view.win      = win;
  end

endmodule

// File: hw/game_pkg.sv
package game_pkg;

  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,
    PH_SET   = 2'd1,
    PH_GAME  = 2'd2,
    PH_FINAL = 2'd3
  } phase_t;

  localparam int TICK_CYCLES = 1000;  // one game second
  localparam int TICK_W      = $clog2(TICK_CYCLES);
  localparam int FINAL_TICKS = 4;
  localparam int FINAL_W     = $clog2(FINAL_TICKS + 1);

  localparam logic [8:0] LFSR_SEED = 9'h160;

  // led patterns
  localparam logic [15:0] LED_IDLE      = 16'h8001;
  localparam logic [15:0] LED_SET_TIME  = 16'hFF01;
  localparam logic [15:0] LED_SET_GOAL  = 16'h80FF;
  localparam logic [6:0]  LED_GAME_TAIL = 7'b0000011;  // below the mole bits

  // two decimal digits
  typedef struct packed {
    logic [3:0] hi;
    logic [3:0] lo;
  } bcd2_t;

  typedef struct packed {
    bcd2_t time_lim;
    bcd2_t goal;
  } settings_t;

  localparam settings_t SETTINGS_DEFAULT = '{
    time_lim: '{hi: 4'd3, lo: 4'd0},
    goal:     '{hi: 4'd1, lo: 4'd0}
  };

  // what the display shows
  typedef struct packed {
    phase_t phase;
    bcd2_t  time_bcd;
    bcd2_t  goal_bcd;  // goal in set, score otherwise
    logic   win;
  } game_view_t;

endpackage

// File: hw/io_pkg.sv
package io_pkg;

  typedef struct packed {
    logic       valid;     // one-cycle strobe
    logic       is_digit;
    logic [3:0] digit;
    logic       is_space;
  } key_event_t;

  // set 2 make codes, index is the digit
  localparam logic [7:0] ROW_CODE [10] = '{
    8'h45, 8'h16, 8'h1E, 8'h26, 8'h25,
    8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
  };
  localparam logic [7:0] PAD_CODE [10] = '{
    8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B,
    8'h73, 8'h74, 8'h6C, 8'h75, 8'h7D
  };
  localparam logic [7:0] SPACE_CODE   = 8'h29;
  localparam logic [7:0] BREAK_PREFIX = 8'hF0;

  typedef logic [3:0] glyph_t;

  localparam glyph_t GLYPH_DASH  = 4'hA;
  localparam glyph_t GLYPH_H     = 4'hB;
  localparam glyph_t GLYPH_L     = 4'hC;
  localparam glyph_t GLYPH_BLANK = 4'hF;

  localparam int SCAN_CYCLES = 16;
  localparam int SCAN_W      = $clog2(SCAN_CYCLES);

  // active low, bit 0 is segment a, bit 6 is g
  localparam logic [6:0] SEG_PATTERN [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30,  // 0..3
    7'h19, 7'h12, 7'h02, 7'h78,  // 4..7
    7'h00, 7'h10, 7'h3F, 7'h09,  // 8, 9, dash, H
    7'h47, 7'h7F, 7'h7F, 7'h7F   // L, then unlit
  };

endpackage

// File: hw/mole_game_top.sv
`timescale 1ns/1ps

module mole_game_top
  import game_pkg::*, io_pkg::*;
(
  input  logic        clk,
  input  logic        out_rst,
  input  logic        start,
  input  logic        ps2_clk,
  input  logic        ps2_data,
  output logic [15:0] leds,
  output logic [3:0]  digit,
  output logic [6:0]  seg
);

  key_event_t key;
  game_view_t view;

  ps2_key_rx u_rx (
    .clk      (clk),
    .out_rst  (out_rst),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .key      (key)
  );

  game_ctrl u_ctrl (
    .clk     (clk),
    .out_rst (out_rst),
    .start   (start),
    .key     (key),
    .leds    (leds),
    .view    (view)
  );

  score_display u_disp (
    .clk     (clk),
    .out_rst (out_rst),
    .view    (view),
    .digit   (digit),
    .seg     (seg)
  );

endmodule

// File: hw/ps2_key_rx.sv
`timescale 1ns/1ps

module ps2_key_rx
  import io_pkg::*;
(
  input  logic       clk,
  input  logic       out_rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output key_event_t key
);

  logic [2:0] clk_sync;  // two sync stages plus edge history
  logic [1:0] dat_sync;
  logic       fall;
  logic       bit_in;

  logic [3:0] bit_cnt;   // 0 hunts for start, 10 is the stop bit
  logic [8:0] shreg;     // data lsb first, parity ends up on top
  logic       brk_pend;

  logic [7:0] code;
  logic       frame_ok;
  key_event_t mapped;

  always_ff @(posedge clk, posedge out_rst) begin
    if (out_rst) begin
      clk_sync <= 3'b111;
      dat_sync <= 2'b11;
    end else begin
      clk_sync <= {clk_sync[1:0], ps2_clk};
      dat_sync <= {dat_sync[0], ps2_data};
    end
  end

  assign fall   = clk_sync[2] & ~clk_sync[1];
  assign bit_in = dat_sync[1];
  assign code   = shreg[7:0];

  // stop bit high and odd parity over data plus parity
  assign frame_ok = bit_in & (^shreg);

  always_ff @(posedge clk) begin
    if (fall && bit_cnt != 4'd0 && bit_cnt != 4'd10)
      shreg <= {bit_in, shreg[8:1]};
  end

  always_ff @(posedge clk, posedge out_rst) begin
    if (out_rst) begin
      bit_cnt  <= '0;
      brk_pend <= 1'b0;
      key      <= '0;
    end else begin
      key.valid <= 1'b0;
      if (fall) begin
        if (bit_cnt == 4'd0) begin
          if (!bit_in)
            bit_cnt <= 4'd1;  // start bit seen
        end else if (bit_cnt == 4'd10) begin
          bit_cnt <= 4'd0;
          if (frame_ok) begin
            if (code == BREAK_PREFIX)
              brk_pend <= 1'b1;
            else if (brk_pend)
              brk_pend <= 1'b0;  // key release, swallowed
            else
              key <= mapped;
          end
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  // make code lookup, unknown codes stay invalid
  always_comb begin
    mapped = '0;
    for (int i = 0; i < 10; i++) begin
      if (code == ROW_CODE[i] || code == PAD_CODE[i]) begin
        mapped.valid    = 1'b1;
        mapped.is_digit = 1'b1;
        mapped.digit    = 4'(i);
      end
    end
    if (code == SPACE_CODE) begin
      mapped.valid    = 1'b1;
      mapped.is_space = 1'b1;
    end
  end

endmodule

// File: hw/score_display.sv
`timescale 1ns/1ps

module score_display
  import game_pkg::*, io_pkg::*;
(
  input  logic       clk,
  input  logic       out_rst,
  input  game_view_t view,
  output logic [3:0] digit,
  output logic [6:0] seg
);

  logic [SCAN_W-1:0] scan_cnt;
  logic              step;
  logic [1:0]        pos;
  glyph_t            glyphs [4];  // index 3 is the leftmost digit
  glyph_t            side;
  glyph_t            cur;

  always_comb begin
    side = view.win ? GLYPH_H : GLYPH_L;
    glyphs[3] = view.time_bcd.hi;
    glyphs[2] = view.time_bcd.lo;
    glyphs[1] = view.goal_bcd.hi;
    glyphs[0] = view.goal_bcd.lo;
    if (view.phase == PH_IDLE) begin
      for (int i = 0; i < 4; i++)
        glyphs[i] = GLYPH_DASH;
    end else if (view.phase == PH_FINAL) begin
      glyphs[3] = side;  // HH or LL, score stays on the right
      glyphs[2] = side;
    end
  end

  assign step = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));

  always_ff @(posedge clk, posedge out_rst) begin
    if (out_rst) begin
      scan_cnt <= '0;
      pos      <= 2'd3;  // first step wraps to digit 0
      digit    <= 4'b1111;
    end else if (step) begin
      scan_cnt <= '0;
      pos      <= pos + 2'd1;
      digit    <= ~(4'b0001 << (pos + 2'd1));
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // segments dark while no anode is driven
  assign cur = (digit == 4'b1111) ? GLYPH_BLANK : glyphs[pos];
  assign seg = SEG_PATTERN[cur];

endmodule

// File: sim/mole_game_assert.sv
`timescale 1ns/1ps

module mole_game_assert
  import game_pkg::*, io_pkg::*;
(
  input logic      clk,
  input logic      out_rst,
  input phase_t    phase,
  input bcd2_t     score,
  input bcd2_t     remain,
  input settings_t settings
);

  int unsigned fails = 0;

  // idle, set, game, final, back to idle
  phase_order: assert property (@(posedge clk) disable iff (out_rst)
    phase != $past(phase) |-> phase == phase_t'($past(phase) + 2'd1))
    else begin
      $error("phase jumped from %0d to %0d", $past(phase), phase);
      fails++;
    end

  score_bound: assert property (@(posedge clk) disable iff (out_rst)
    (phase == PH_GAME || phase == PH_FINAL) |-> score <= settings.goal)
    else begin
      $error("score %0h above goal %0h", score, settings.goal);
      fails++;
    end

  // bcd compares like binary
  time_falls: assert property (@(posedge clk) disable iff (out_rst)
    (phase == PH_GAME && $past(phase) == PH_GAME) |-> remain <= $past(remain))
    else begin
      $error("remaining time rose to %0h", remain);
      fails++;
    end

endmodule

bind game_ctrl mole_game_assert u_assert (
  .clk, .out_rst, .phase, .score, .remain, .settings
);

// File: sim/mole_game_tb.sv
`timescale 1ns/1ps

module mole_game_tb
  import game_pkg::*, io_pkg::*;
();

  typedef struct packed {
    int    id;
    bcd2_t time_lim;
    bcd2_t goal;
    int    hits;
    int    misses;
    int    bad;
  } test_t;

  logic        clk;
  logic        out_rst;
  logic        start;
  logic        ps2_clk;
  logic        ps2_data;
  logic [15:0] leds;
  logic [3:0]  digit;
  logic [6:0]  seg;

  int unsigned cycle = 0;
  int unsigned seed;
  int          errors;
  int          failed;
  int          limit = 0;
  test_t       tests [$];
  glyph_t      seen [4];  // last glyph seen per anode

  mole_game_top DUT (.*);

  always #10 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // seven segment decode, active low, a in bit 0
  function automatic glyph_t seg_glyph(logic [6:0] s);
    case (s)
      7'h40:   return 4'd0;
      7'h79:   return 4'd1;
      7'h24:   return 4'd2;
      7'h30:   return 4'd3;
      7'h19:   return 4'd4;
      7'h12:   return 4'd5;
      7'h02:   return 4'd6;
      7'h78:   return 4'd7;
      7'h00:   return 4'd8;
      7'h10:   return 4'd9;
      7'h3F:   return GLYPH_DASH;
      7'h09:   return GLYPH_H;
      7'h47:   return GLYPH_L;
      7'h7F:   return GLYPH_BLANK;
      default: return 4'hE;  // not a known pattern
    endcase
  endfunction

  always @(negedge clk) begin
    for (int i = 0; i < 4; i++)
      if (!digit[i]) seen[i] <= seg_glyph(seg);
  end

  function automatic bcd2_t to_bcd(int v);
    return '{hi: 4'(v / 10), lo: 4'(v % 10)};
  endfunction

  // digit 1..9 whose mole led matches lit, 0 if none
  function automatic int pick_mole(logic lit);
    int s;
    int k;
    s = $urandom % 9;
    for (int i = 0; i < 9; i++) begin
      k = (s + i) % 9 + 1;
      if (leds[k + 6] == lit) return k;
    end
    return 0;
  endfunction

  task automatic mismatch(string name, logic [31:0] exp, logic [31:0] act);
    errors++;
    $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  task automatic wait_to(int unsigned c);
    while (cycle < c) @(negedge clk);
  endtask

  task automatic pulse_start();
    @(negedge clk) start = 1'b1;
    @(negedge clk) start = 1'b0;
  endtask

  // start, 8 data lsb first, odd parity, stop
  task automatic send_frame(logic [7:0] code, logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_data = bits[i];
      repeat (8) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (8) @(negedge clk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic press(int d, logic bad_parity);
    send_frame(($urandom & 1) ? PAD_CODE[d] : ROW_CODE[d], bad_parity);
  endtask

  task automatic check_display(logic [15:0] exp);
    seen = '{default: 4'hE};
    repeat (4 * SCAN_CYCLES + 4) @(negedge clk);
    if ({seen[3], seen[2], seen[1], seen[0]} !== exp)
      mismatch("seg", exp, {seen[3], seen[2], seen[1], seen[0]});
  endtask

  task automatic read_trace();
    int    fd;
    int    col [6];
    string line;
    test_t t;
    fd = $fopen("sim/mole_trace.txt", "r");
    if (fd == 0) return;
    while ($fgets(line, fd) > 0) begin
      if ($sscanf(line, "%d %h %h %d %d %d",
                  col[0], col[1], col[2], col[3], col[4], col[5]) == 6) begin
        t.id       = col[0];
        t.time_lim = col[1][7:0];
        t.goal     = col[2][7:0];
        t.hits     = col[3];
        t.misses   = col[4];
        t.bad      = col[5];
        tests.push_back(t);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(test_t t);
    int          err0;
    int          ticks;
    int          goal;
    int          score;
    int          hits;
    int          misses;
    int          bad;
    int          k;
    int unsigned t0;
    int unsigned base;
    int unsigned fin;
    logic        won;
    glyph_t      side;
    err0   = errors;
    ticks  = t.time_lim.hi * 10 + t.time_lim.lo;
    goal   = t.goal.hi * 10 + t.goal.lo;
    hits   = t.hits;
    misses = t.misses;
    bad    = t.bad;
    score  = 0;
    won    = 1'b0;

    if (leds !== 16'h8001) mismatch("leds", 16'h8001, leds);
    check_display({4{GLYPH_DASH}});
    pulse_start();
    if (leds !== 16'hFF01) mismatch("leds", 16'hFF01, leds);
    check_display(16'h3010);  // defaults 30 and 10
    press(t.time_lim.hi, 1'b0);
    check_display({4'd0, t.time_lim.hi, 8'h10});
    press(t.time_lim.lo, 1'b0);
    press((t.time_lim.lo + 1) % 10, 1'b1);  // broken parity, ignored
    check_display({t.time_lim, 8'h10});
    send_frame(SPACE_CODE, 1'b0);
    if (leds !== 16'h80FF) mismatch("leds", 16'h80FF, leds);
    press(t.goal.hi, 1'b0);
    press(t.goal.lo, 1'b0);
    check_display({t.time_lim, t.goal});
    pulse_start();
    t0  = cycle;
    fin = t0 + ticks * TICK_CYCLES + 1;  // entry to final when time runs out

    for (int n = 0; n < ticks && !won; n++) begin
      base = t0 + n * TICK_CYCLES;
      k    = 0;
      wait_to(base + 10);
      if (hits > 0) begin
        k = pick_mole(1'b1);
        press(k, 1'b0);
        hits--;
        score++;
        if (score == goal) begin
          won = 1'b1;
          fin = cycle;
        end else if (leds[k + 6] !== 1'b0) begin
          mismatch("leds mole bit", 0, leds[k + 6]);
        end
      end
      if (!won) begin
        wait_to(base + 210);
        if (misses > 0) begin
          press((k != 0) ? k : pick_mole(1'b0), 1'b0);  // repeat or unlit
          misses--;
        end
        wait_to(base + 410);
        if (bad > 0) begin
          if (bad % 2) begin
            press(pick_mole(1'b1), 1'b1);
          end else begin
            send_frame(BREAK_PREFIX, 1'b0);
            press(pick_mole(1'b1), 1'b0);  // release code, no hit
          end
          bad--;
        end
        wait_to(base + 800);
        check_display({to_bcd(ticks - n), to_bcd(score)});
      end
    end

    side = won ? GLYPH_H : GLYPH_L;
    wait_to(fin + 20);
    check_display({side, side, to_bcd(score)});
    wait_to(fin + TICK_CYCLES / 2);
    if (leds !== 16'hFFFF) mismatch("leds", 16'hFFFF, leds);
    wait_to(fin + TICK_CYCLES * 3 / 2);
    if (leds !== 16'h0000) mismatch("leds", 16'h0000, leds);
    wait_to(fin + FINAL_TICKS * TICK_CYCLES - 100);
    if (leds !== 16'h0000) mismatch("leds", 16'h0000, leds);  // fourth tick dark
    wait_to(fin + FINAL_TICKS * TICK_CYCLES + 100);
    if (leds !== 16'h8001) mismatch("leds", 16'h8001, leds);
    if (errors != err0) failed++;
    $display("test %0d %s, score %0d: %s", t.id, won ? "win" : "loss", score,
             (errors == err0) ? "ok" : "failed");
  endtask

  initial begin
    int maxt;
    int asserts;
    clk      = 1'b0;
    out_rst  = 1'b1;
    start    = 1'b0;
    ps2_clk  = 1'b1;
    ps2_data = 1'b1;
    errors   = 0;
    failed   = 0;
    maxt     = 0;
    seed     = $urandom(32'h0ab9f03b);
    read_trace();
    if (tests.size() == 0) begin
      $display("no test lines could be read from sim/mole_trace.txt");
      $display("** FAIL **");
    end else begin
      foreach (tests[i])
        if (tests[i].time_lim.hi * 10 + tests[i].time_lim.lo > maxt)
          maxt = tests[i].time_lim.hi * 10 + tests[i].time_lim.lo;
      limit = tests.size() * (maxt + FINAL_TICKS + 2) * TICK_CYCLES;
      repeat (10) @(negedge clk);
      out_rst = 1'b0;
      foreach (tests[i])
        run_test(tests[i]);
      asserts = DUT.u_ctrl.u_assert.fails;
      $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
               tests.size(), failed, errors, asserts);
      if (errors == 0 && asserts == 0)
        $display("** PASS **");
      else
        $display("** FAIL **");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("watchdog timeout after %0d cycles, run stopped", limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: sim/mole_trace.txt
# id  time(bcd)  goal(bcd)  hits  misses  bad_frames
# a win needs hits equal to goal within the time limit
1  05  03  3  2  2
2  04  05  2  3  3
3  06  02  2  1  1
4  11  10  4  4  2
5  03  01  1  0  0

// File: tb.f
hw/game_pkg.sv
hw/io_pkg.sv
hw/ps2_key_rx.sv
hw/game_ctrl.sv
hw/score_display.sv
hw/mole_game_top.sv
sim/mole_game_assert.sv
sim/mole_game_tb.sv
